/* verilog/sm3_const_pkg.sv */
`default_nettype none

package sm3_const_pkg;

    ////////////////////////////////////////////////////////////
    // initial value and round constants
    ////////////////////////////////////////////////////////////
    localparam logic [31:0] IV0 = 32'h7380166f;
    localparam logic [31:0] IV1 = 32'h4914b2b9;
    localparam logic [31:0] IV2 = 32'h172442d7;
    localparam logic [31:0] IV3 = 32'hda8a0600;
    localparam logic [31:0] IV4 = 32'ha96f30bc;
    localparam logic [31:0] IV5 = 32'h163138aa;
    localparam logic [31:0] IV6 = 32'he38dee4d;
    localparam logic [31:0] IV7 = 32'hb0fb0e4e;

    localparam logic [31:0] T_EARLY = 32'h79cc4519;  // rounds 0..15
    localparam logic [31:0] T_LATE  = 32'h9d8a7a87;  // rounds 16..63, already <<< 16

    // round counter schedule, two rounds per count
    localparam int                  ROUND_W          = 7;
    localparam logic [ROUND_W-1:0] BEAT_LAST        = 7'd7;   // last input beat
    localparam logic [ROUND_W-1:0] ROUND_PREP       = 7'd3;   // first wj pair, tj load
    localparam logic [ROUND_W-1:0] ROUND_FIRST_CALC = 7'd4;
    localparam logic [ROUND_W-1:0] ROUND_T_RELOAD   = 7'd11;
    localparam logic [ROUND_W-1:0] ROUND_FF_SWITCH  = 7'd12;
    localparam logic [ROUND_W-1:0] ROUND_LAST       = 7'd35;  // fold cycle
    localparam logic [ROUND_W-1:0] ROUND_DONE       = 7'd36;

    // rotation amounts
    localparam int unsigned ROT_W3   = 15;  // W[j-3] in expansion
    localparam int unsigned ROT_W13  = 7;   // W[j-13] in expansion
    localparam int unsigned ROT_P1_A = 15;
    localparam int unsigned ROT_P1_B = 23;
    localparam int unsigned ROT_P0_A = 9;
    localparam int unsigned ROT_P0_B = 17;
    localparam int unsigned ROT_SS_A = 12;
    localparam int unsigned ROT_SS_B = 7;
    localparam int unsigned ROT_B    = 9;
    localparam int unsigned ROT_F    = 19;
    localparam int unsigned TJ_STEP  = 2;   // tj advance per double round

endpackage

`default_nettype wire

/* verilog/sm3_types_pkg.sv */
`default_nettype none

package sm3_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] beat_t;  // [63:32] is the earlier word
    typedef logic [sm3_const_pkg::ROUND_W-1:0] round_t;

    ////////////////////////////////////////////////////////////
    // chaining state, A in the top word
    ////////////////////////////////////////////////////////////
    typedef union packed {
        logic [255:0] flat;   // digest view
        word_t [0:7]  w;      // w[0] = A ... w[7] = H
    } state_u;

    // left rotate of one word
    function automatic word_t rol(word_t x, int unsigned n);
        return (x << n) | (x >> (32 - n));
    endfunction

endpackage

`default_nettype wire

/* verilog/sm3_round_ctrl.sv */
`default_nettype none

module sm3_round_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  input_valid,
    output sm3_types_pkg::round_t round_cnt,
    output logic                  start,
    output logic                  input_ready,
    output logic                  output_valid
);

    logic idle;

    assign idle = (round_cnt == '0);

    // valid only matters at idle, beats then follow back to back
    assign start = idle && input_valid;

    ////////////////////////////////////////////////////////////
    // round counter
    ////////////////////////////////////////////////////////////
    // sits at 0, then runs 1..36 and wraps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            round_cnt <= '0;
        end else if (round_cnt == sm3_const_pkg::ROUND_DONE) begin
            round_cnt <= '0;
        end else if (start || !idle) begin
            round_cnt <= round_cnt + 1'b1;
        end
    end

    // status decode
    assign input_ready  = idle;
    assign output_valid = (round_cnt == sm3_const_pkg::ROUND_DONE);  // one cycle only

endmodule

`default_nettype wire

/* verilog/sm3_msg_expand.sv */
`default_nettype none

module sm3_msg_expand (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sm3_types_pkg::round_t round_cnt,
    input  logic                  start,
    input  sm3_types_pkg::beat_t  din,
    output sm3_types_pkg::word_t  wj_lo,
    output sm3_types_pkg::word_t  wj_hi,
    output sm3_types_pkg::word_t  wjp_lo,
    output sm3_types_pkg::word_t  wjp_hi
);

    sm3_types_pkg::word_t w [0:20];   // sliding window
    sm3_types_pkg::word_t w_stage;    // first half of a split expansion
    sm3_types_pkg::word_t w_new_lo;
    sm3_types_pkg::word_t w_new_hi;
    logic                 load_beat;
    logic [3:0]           beat_slot;
    logic [4:0]           pair_base;

    // W[j-16] ^ W[j-9] ^ (W[j-3] <<< 15)
    function automatic sm3_types_pkg::word_t mix(
        sm3_types_pkg::word_t m16,
        sm3_types_pkg::word_t m9,
        sm3_types_pkg::word_t m3
    );
        return m16 ^ m9 ^ sm3_types_pkg::rol(m3, sm3_const_pkg::ROT_W3);
    endfunction

    // P1 of the mix, then W[j-13] and W[j-6]
    function automatic sm3_types_pkg::word_t finish(
        sm3_types_pkg::word_t x,
        sm3_types_pkg::word_t m13,
        sm3_types_pkg::word_t m6
    );
        sm3_types_pkg::word_t p1;
        p1 = x ^ sm3_types_pkg::rol(x, sm3_const_pkg::ROT_P1_A)
               ^ sm3_types_pkg::rol(x, sm3_const_pkg::ROT_P1_B);
        return p1 ^ sm3_types_pkg::rol(m13, sm3_const_pkg::ROT_W13) ^ m6;
    endfunction

    assign load_beat = start ||
                       (round_cnt != '0 && round_cnt <= sm3_const_pkg::BEAT_LAST);
    assign beat_slot = {round_cnt[2:0], 1'b0};
    assign pair_base = 5'((round_cnt - sm3_const_pkg::ROUND_PREP) << 1);

    // the two words entering the window while it slides
    assign w_new_lo = finish(mix(w[5], w[12], w[18]), w[8], w[15]);
    assign w_new_hi = finish(mix(w[6], w[13], w[19]), w[9], w[16]);

    ////////////////////////////////////////////////////////////
    // window: load, early expansion, slide
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (load_beat) begin
            w[beat_slot]        <= din[63:32];
            w[beat_slot + 4'd1] <= din[31:0];
        end else if (round_cnt == sm3_const_pkg::BEAT_LAST + 7'd1) begin
            w[16]   <= finish(mix(w[0], w[7], w[13]), w[3], w[10]);
            w[17]   <= finish(mix(w[1], w[8], w[14]), w[4], w[11]);
            w_stage <= mix(w[2], w[9], w[15]);  // for w18
        end else if (round_cnt == sm3_const_pkg::BEAT_LAST + 7'd2) begin
            w[18]   <= finish(w_stage, w[5], w[12]);
            w[19]   <= finish(mix(w[3], w[10], w[16]), w[6], w[13]);
            w_stage <= mix(w[4], w[11], w[17]);  // for w20
        end else if (round_cnt == sm3_const_pkg::BEAT_LAST + 7'd3) begin
            w[20] <= finish(w_stage, w[7], w[14]);
        end else if (round_cnt >= sm3_const_pkg::ROUND_T_RELOAD &&
                     round_cnt <  sm3_const_pkg::ROUND_LAST) begin
            for (int i = 0; i < 19; i++) begin
                w[i] <= w[i + 2];
            end
            w[19] <= w_new_lo;
            w[20] <= w_new_hi;
        end
    end

    ////////////////////////////////////////////////////////////
    // wj / wj' pair for the next double round
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wj_lo  <= '0;
            wj_hi  <= '0;
            wjp_lo <= '0;
            wjp_hi <= '0;
        end else if (round_cnt >= sm3_const_pkg::ROUND_PREP &&
                     round_cnt <  sm3_const_pkg::ROUND_T_RELOAD) begin
            // window still filling, pick by position
            wj_lo  <= w[pair_base];
            wj_hi  <= w[pair_base + 5'd1];
            wjp_lo <= w[pair_base] ^ w[pair_base + 5'd4];
            wjp_hi <= w[pair_base + 5'd1] ^ w[pair_base + 5'd5];
        end else if (round_cnt >= sm3_const_pkg::ROUND_T_RELOAD &&
                     round_cnt <  sm3_const_pkg::ROUND_LAST) begin
            wj_lo  <= w[16];
            wj_hi  <= w[17];
            wjp_lo <= w[16] ^ w[20];
            wjp_hi <= w[17] ^ w_new_lo;  // W[2j+5] not stored yet
        end
    end

endmodule

`default_nettype wire

/* verilog/sm3_round_pair.sv */
`default_nettype none

module sm3_round_pair (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sm3_types_pkg::round_t round_cnt,
    input  sm3_types_pkg::state_u state,
    input  sm3_types_pkg::word_t  wj_lo,
    input  sm3_types_pkg::word_t  wj_hi,
    input  sm3_types_pkg::word_t  wjp_lo,
    input  sm3_types_pkg::word_t  wjp_hi,
    output sm3_types_pkg::state_u next_state
);

    sm3_types_pkg::word_t  tj_lo;      // Tj <<< 2j
    sm3_types_pkg::word_t  tj_hi;      // one step ahead
    sm3_types_pkg::state_u mid_state;  // after round 2j
    logic                  xor_form;

    function automatic sm3_types_pkg::word_t p0(sm3_types_pkg::word_t x);
        return x ^ sm3_types_pkg::rol(x, sm3_const_pkg::ROT_P0_A)
                 ^ sm3_types_pkg::rol(x, sm3_const_pkg::ROT_P0_B);
    endfunction

    ////////////////////////////////////////////////////////////
    // single compression round
    ////////////////////////////////////////////////////////////
    function automatic sm3_types_pkg::state_u one_round(
        sm3_types_pkg::state_u s,
        sm3_types_pkg::word_t  tj,
        sm3_types_pkg::word_t  wj,
        sm3_types_pkg::word_t  wjp,
        logic                  early
    );
        sm3_types_pkg::word_t  a12;
        sm3_types_pkg::word_t  ss1;
        sm3_types_pkg::word_t  ss2;
        sm3_types_pkg::word_t  ff;
        sm3_types_pkg::word_t  gg;
        sm3_types_pkg::word_t  tt1;
        sm3_types_pkg::word_t  tt2;
        sm3_types_pkg::state_u r;
        a12 = sm3_types_pkg::rol(s.w[0], sm3_const_pkg::ROT_SS_A);
        ss1 = sm3_types_pkg::rol(a12 + s.w[4] + tj, sm3_const_pkg::ROT_SS_B);
        ss2 = ss1 ^ a12;
        if (early) begin
            ff = s.w[0] ^ s.w[1] ^ s.w[2];
            gg = s.w[4] ^ s.w[5] ^ s.w[6];
        end else begin
            ff = (s.w[0] & s.w[1]) | (s.w[0] & s.w[2]) | (s.w[1] & s.w[2]);  // majority
            gg = (s.w[4] & s.w[5]) | (~s.w[4] & s.w[6]);                     // choose
        end
        tt1 = ff + s.w[3] + ss2 + wjp;
        tt2 = gg + s.w[7] + ss1 + wj;
        r.w[0] = tt1;
        r.w[1] = s.w[0];
        r.w[2] = sm3_types_pkg::rol(s.w[1], sm3_const_pkg::ROT_B);
        r.w[3] = s.w[2];
        r.w[4] = p0(tt2);
        r.w[5] = s.w[4];
        r.w[6] = sm3_types_pkg::rol(s.w[5], sm3_const_pkg::ROT_F);
        r.w[7] = s.w[6];
        return r;
    endfunction

    // tj pair: load, reload for late rounds, else rotate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tj_lo <= '0;
            tj_hi <= '0;
        end else if (round_cnt == sm3_const_pkg::ROUND_PREP) begin
            tj_lo <= sm3_const_pkg::T_EARLY;
            tj_hi <= sm3_types_pkg::rol(sm3_const_pkg::T_EARLY, 1);
        end else if (round_cnt == sm3_const_pkg::ROUND_T_RELOAD) begin
            tj_lo <= sm3_const_pkg::T_LATE;
            tj_hi <= sm3_types_pkg::rol(sm3_const_pkg::T_LATE, 1);
        end else begin
            tj_lo <= sm3_types_pkg::rol(tj_lo, sm3_const_pkg::TJ_STEP);
            tj_hi <= sm3_types_pkg::rol(tj_hi, sm3_const_pkg::TJ_STEP);
        end
    end

    assign xor_form   = (round_cnt < sm3_const_pkg::ROUND_FF_SWITCH);  // rounds 0..15
    assign mid_state  = one_round(state, tj_lo, wj_lo, wjp_lo, xor_form);
    assign next_state = one_round(mid_state, tj_hi, wj_hi, wjp_hi, xor_form);

endmodule

`default_nettype wire

/* verilog/sm3_state_reg.sv */
`default_nettype none

module sm3_state_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sm3_types_pkg::round_t round_cnt,
    input  logic                  start,
    input  logic [63:0]           input_block_index,
    input  sm3_types_pkg::state_u next_state,
    output sm3_types_pkg::state_u state
);

    sm3_types_pkg::state_u chain;  // V(i) for the final fold
    sm3_types_pkg::state_u iv;

    always_comb begin
        iv.w[0] = sm3_const_pkg::IV0;
        iv.w[1] = sm3_const_pkg::IV1;
        iv.w[2] = sm3_const_pkg::IV2;
        iv.w[3] = sm3_const_pkg::IV3;
        iv.w[4] = sm3_const_pkg::IV4;
        iv.w[5] = sm3_const_pkg::IV5;
        iv.w[6] = sm3_const_pkg::IV6;
        iv.w[7] = sm3_const_pkg::IV7;
    end

    // new message restarts from the IV, later blocks chain
    always_ff @(posedge clk) begin
        if (start) begin
            chain <= (input_block_index == 64'd0) ? iv : state;
        end
    end

    ////////////////////////////////////////////////////////////
    // working registers A..H
    ////////////////////////////////////////////////////////////
    // last digest stays visible until the block's working copy loads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= '0;
        end else if (round_cnt == sm3_const_pkg::ROUND_PREP) begin
            state <= chain;
        end else if (round_cnt >= sm3_const_pkg::ROUND_FIRST_CALC &&
                     round_cnt <  sm3_const_pkg::ROUND_LAST) begin
            state <= next_state;
        end else if (round_cnt == sm3_const_pkg::ROUND_LAST) begin
            for (int i = 0; i < 8; i++) begin
                state.w[i] <= next_state.w[i] ^ chain.w[i];  // V(i+1)
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/sm3_compress_top.sv */
`default_nettype none

module sm3_compress_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 input_valid,
    input  logic [63:0]          input_block_index,
    input  sm3_types_pkg::beat_t din,
    output logic                 input_ready,
    output logic                 output_valid,
    output logic [255:0]         dout
);

    sm3_types_pkg::round_t round_cnt;
    logic                  start;
    sm3_types_pkg::word_t  wj_lo;
    sm3_types_pkg::word_t  wj_hi;
    sm3_types_pkg::word_t  wjp_lo;
    sm3_types_pkg::word_t  wjp_hi;
    sm3_types_pkg::state_u state;
    sm3_types_pkg::state_u next_state;

    sm3_round_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .input_valid  (input_valid),
        .round_cnt    (round_cnt),
        .start        (start),
        .input_ready  (input_ready),
        .output_valid (output_valid)
    );

    sm3_msg_expand u_expand (
        .clk       (clk),
        .rst_n     (rst_n),
        .round_cnt (round_cnt),
        .start     (start),
        .din       (din),
        .wj_lo     (wj_lo),
        .wj_hi     (wj_hi),
        .wjp_lo    (wjp_lo),
        .wjp_hi    (wjp_hi)
    );

    sm3_round_pair u_round (
        .clk        (clk),
        .rst_n      (rst_n),
        .round_cnt  (round_cnt),
        .state      (state),
        .wj_lo      (wj_lo),
        .wj_hi      (wj_hi),
        .wjp_lo     (wjp_lo),
        .wjp_hi     (wjp_hi),
        .next_state (next_state)
    );

    sm3_state_reg u_state (
        .clk               (clk),
        .rst_n             (rst_n),
        .round_cnt         (round_cnt),
        .start             (start),
        .input_block_index (input_block_index),
        .next_state        (next_state),
        .state             (state)
    );

    assign dout = state.flat;

endmodule

`default_nettype wire

/* tb/sm3_compress_asserts.sv */
`default_nettype none

module sm3_compress_asserts (
    input logic         clk,
    input logic         rst_n,
    input logic         input_valid,
    input logic         input_ready,
    input logic         output_valid,
    input logic [255:0] dout
);

    logic accepted;
    int   fail_cnt = 0;  // read by the testbench

    assign accepted = input_ready && input_valid;

    ////////////////////////////////////////////////////////////
    // latency and ready window
    ////////////////////////////////////////////////////////////
    // done is a single pulse, 36 cycles after the start edge
    done_timing: assert property (@(posedge clk) disable iff (!rst_n)
        output_valid == $past(accepted, 36))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("output_valid not exactly 36 cycles after an accepted start");
        end

    busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accepted) |-> !input_ready)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("input_ready still high one cycle after start");
        end

    // ready comes back right after done, and only then
    ready_return: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(input_ready) == $past(output_valid))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("input_ready did not return one cycle after done");
        end

    // digest held while idle and for three cycles after the next start
    dout_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (input_ready || $past(accepted) || $past(accepted, 2) || $past(accepted, 3))
            |-> $stable(dout))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("dout changed before the next block reached its compress cycles");
        end

endmodule

`default_nettype wire

/* tb/sm3_compress_tb.sv */
`default_nettype none

module sm3_compress_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_GAP      = 20;  // idle cycles between blocks
    localparam int BLOCK_CYCLES = 37;  // start through ready again
    localparam int BLOCK_BUDGET = 20;
    localparam int PASSES       = 3;   // four blocks per pass
    localparam int WATCHDOG     = RESET_CYCLES + BLOCK_BUDGET * (BLOCK_CYCLES + MAX_GAP);

    // padded example blocks and published digests
    localparam logic [511:0] ABC_BLOCK   = {32'h61626380, 448'h0, 32'h00000018};
    localparam logic [511:0] ABCD_BLOCK0 = {16{32'h61626364}};
    localparam logic [511:0] ABCD_BLOCK1 = {32'h80000000, 448'h0, 32'h00000200};
    localparam logic [255:0] ABC_DIGEST  =
        256'h66c7f0f4_62eeedd9_d1f2d46b_dc10e4e2_4167c487_5cf2f7a2_297da02b_8f4ba8e0;
    localparam logic [255:0] ABCD_DIGEST =
        256'hdebe9ff9_2275b8a1_38604889_c18e5a4d_6fdb70e5_387e5765_293dcba3_9c0c5732;

    logic         clk;
    logic         rst_n;
    logic         input_valid;
    logic [63:0]  input_block_index;
    logic [63:0]  din;
    logic         input_ready;
    logic         output_valid;
    logic [255:0] dout;
    logic [31:0]  rng;  // gap generator state

    sm3_compress_top sm3_compress_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .input_valid       (input_valid),
        .input_block_index (input_block_index),
        .din               (din),
        .input_ready       (input_ready),
        .output_valid      (output_valid),
        .dout              (dout)
    );

    bind sm3_compress_top sm3_compress_asserts asserts_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .dout         (dout)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG);
        $display("sim failed");
        $fatal(1);
    end

    always @(negedge clk) begin
        if (sm3_compress_top_i.asserts_i.fail_cnt != 0) begin
            $display("a bound protocol assertion failed");
            $display("sim failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'h41c64e6d + 32'h00003039;
    endfunction

    task automatic check_equal(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one block: idle gap, eight beats, wait for done
    ////////////////////////////////////////////////////////////
    task automatic hash_block(input logic [511:0] blk, input logic [63:0] idx,
                              input logic check, input logic [255:0] expected);
        int gap;
        int wait_cnt;
        rng = lcg_next(rng);
        gap = (rng >> 16) % (MAX_GAP + 1);
        repeat (gap) @(posedge clk);
        @(negedge clk);
        while (!input_ready) @(negedge clk);
        @(posedge clk);
        input_valid       <= 1'b1;
        input_block_index <= idx;
        din               <= blk[511 -: 64];  // beat 0 with the start
        for (int i = 1; i < 8; i++) begin
            @(posedge clk);
            input_valid <= 1'b0;
            din         <= blk[511 - 64 * i -: 64];
        end
        wait_cnt = 0;
        while (!output_valid && wait_cnt < BLOCK_CYCLES) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!output_valid) begin
            $display("timeout: no output_valid after the block was sent");
            $display("sim failed");
            $fatal(1);
        end
        if (check) begin
            check_equal("dout", expected, dout);
        end
    endtask

    initial begin
        rst_n             = 1'b0;
        input_valid       = 1'b0;
        input_block_index = '0;
        din               = '0;
        rng               = 32'h3879;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_equal("input_ready", 256'(1'b1), 256'(input_ready));
        check_equal("output_valid", 256'(1'b0), 256'(output_valid));
        check_equal("dout", '0, dout);
        for (int pass = 0; pass < PASSES; pass++) begin
            hash_block(ABC_BLOCK, 64'd0, 1'b1, ABC_DIGEST);
            hash_block(ABCD_BLOCK0, 64'd0, 1'b0, '0);  // intermediate value
            hash_block(ABCD_BLOCK1, 64'd1, 1'b1, ABCD_DIGEST);
            hash_block(ABC_BLOCK, 64'd0, 1'b1, ABC_DIGEST);  // IV reload after chaining
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (sm3_compress_top_i.asserts_i.fail_cnt != 0) begin
            $display("bound protocol assertions failed");
            $display("sim failed");
            $fatal(1);
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* files.f */
verilog/sm3_const_pkg.sv
verilog/sm3_types_pkg.sv
verilog/sm3_round_ctrl.sv
verilog/sm3_msg_expand.sv
verilog/sm3_round_pair.sv
verilog/sm3_state_reg.sv
verilog/sm3_compress_top.sv
tb/sm3_compress_asserts.sv
tb/sm3_compress_tb.sv

/* Makefile */
# Verilator flow for the SM3 compression engine

TOP       ?= sm3_compress_tb
SIM_DIR   ?= sim_build
LOG       ?= $(SIM_DIR)/sim.log
FILELIST  ?= files.f
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert --top-module $(TOP)
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST)

sim:
	mkdir -p $(SIM_DIR)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --Mdir $(SIM_DIR)/obj
	$(SIM_DIR)/obj/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(SIM_DIR)
